/* filelist.f */
+incdir+verilog
+incdir+testbench
verilog/trace_pkg.sv
verilog/commit_classifier.sv
verilog/trace_queue.sv
verilog/trace_arbiter.sv
verilog/trace_top.sv
testbench/tb_trace_top.sv

/* testbench/tb_trace_vectors.svh */
`ifndef TB_TRACE_VECTORS_SVH
`define TB_TRACE_VECTORS_SVH

// one row per clock, bit 0 of ack and ex belongs to port 0
// columns: ack, pc0, insn0, pc1, insn1, ex, cause0, cause1, priv, debug, credit hold
typedef struct packed {
  logic [`TRACE_PORTS-1:0] ack;
  trace_pkg::pc_t          pc0;
  trace_pkg::insn_t        insn0;
  trace_pkg::pc_t          pc1;
  trace_pkg::insn_t        insn1;
  logic [`TRACE_PORTS-1:0] ex;
  trace_pkg::cause_t       cause0;
  trace_pkg::cause_t       cause1;
  logic [1:0]              priv;
  logic                    dbg;
  logic                    hold;
} vec_row_t;

localparam int NumRows = 45;

vec_row_t vec_table [NumRows];
int       row_fill = 0;

task automatic add_row(
  input logic [`TRACE_PORTS-1:0] ack,
  input trace_pkg::pc_t          pc0,
  input trace_pkg::insn_t        insn0,
  input trace_pkg::pc_t          pc1,
  input trace_pkg::insn_t        insn1,
  input logic [`TRACE_PORTS-1:0] ex,
  input trace_pkg::cause_t       cause0,
  input trace_pkg::cause_t       cause1,
  input logic [1:0]              priv,
  input logic                    dbg,
  input logic                    hold
);
  vec_table[row_fill] = {ack, pc0, insn0, pc1, insn1, ex, cause0, cause1, priv, dbg, hold};
  row_fill = row_fill + 1;
endtask

task automatic idle_row(input logic hold);
  add_row(2'b00, 'h0, 'h0, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, hold);
endtask

task automatic load_table();
  // retire stream on port 0, machine mode
  add_row(2'b01, 'h8000_0000, 'h0000_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b0);
  add_row(2'b01, 'h8000_0004, 'h0010_0093, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b0);
  add_row(2'b01, 'h8000_0008, 'h0020_8133, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b0);
  repeat (3) idle_row(1'b0);
  // traps, privilege levels and debug override
  add_row(2'b01, 'h8000_0100, 'h0000_0000, 'h0, 'h0, 2'b01, 'h02, 'h00, 2'd1, 1'b0, 1'b0);
  add_row(2'b10, 'h0, 'h0, 'h8000_0200, 'h0000_0073, 2'b10, 'h00, 'h87, 2'd0, 1'b0, 1'b0);
  add_row(2'b11, 'h8000_0104, 'h0010_0073, 'h8000_0204, 'h7b20_0073, 2'b00, 'h00, 'h00,
          2'd0, 1'b1, 1'b0);
  add_row(2'b01, 'h8000_0108, 'h0000_0073, 'h0, 'h0, 2'b01, 'h8b, 'h00, 2'd3, 1'b1, 1'b0);
  add_row(2'b10, 'h0, 'h0, 'h8000_0208, 'h0000_3003, 2'b10, 'h00, 'h0d, 2'd1, 1'b1, 1'b0);
  repeat (4) idle_row(1'b0);
  // both ports in the same cycles
  add_row(2'b11, 'h8000_1000, 'h0040_0113, 'h8000_2000, 'h0050_0193, 2'b00, 'h00, 'h00,
          2'd3, 1'b0, 1'b0);
  add_row(2'b11, 'h8000_1004, 'h0060_0213, 'h8000_2004, 'h0070_0293, 2'b00, 'h00, 'h00,
          2'd3, 1'b0, 1'b0);
  add_row(2'b11, 'h8000_1008, 'h0080_0313, 'h8000_2008, 'h0000_2003, 2'b10, 'h00, 'h05,
          2'd3, 1'b0, 1'b0);
  repeat (10) idle_row(1'b0);
  // consumer withholds credits, port 1 uses them up
  add_row(2'b10, 'h0, 'h0, 'h8000_3000, 'h0010_0013, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b10, 'h0, 'h0, 'h8000_3004, 'h0020_0013, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b10, 'h0, 'h0, 'h8000_3008, 'h0030_0013, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  repeat (4) idle_row(1'b1);
  // port 0 fills its queue and then overflows
  add_row(2'b01, 'h8000_4000, 'h0100_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b01, 'h8000_4004, 'h0200_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b01, 'h8000_4008, 'h0300_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b01, 'h8000_400c, 'h0400_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b01, 'h8000_4010, 'h0500_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  add_row(2'b01, 'h8000_4014, 'h0600_0013, 'h0, 'h0, 2'b00, 'h00, 'h00, 2'd3, 1'b0, 1'b1);
  repeat (2) idle_row(1'b1);
  // credits flow again
  repeat (2) idle_row(1'b0);
endtask

`endif

/* testbench/tb_trace_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module tb_trace_top;

  `include "tb_trace_vectors.svh"

  localparam int BufDepth = 64;

  typedef struct packed {
    trace_pkg::pc_t         pc;
    trace_pkg::insn_t       insn;
    trace_pkg::cause_t      cause;
    trace_pkg::trace_kind_e kind;
    trace_pkg::trace_mode_e mode;
    trace_pkg::cycle_t      cycle;
  } exp_rec_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [`TRACE_PORTS-1:0] commit_ack;
  trace_pkg::pc_t          commit_pc    [`TRACE_PORTS];
  trace_pkg::insn_t        commit_insn  [`TRACE_PORTS];
  logic [`TRACE_PORTS-1:0] commit_ex_valid;
  trace_pkg::cause_t       commit_cause [`TRACE_PORTS];
  trace_pkg::priv_lvl_e    priv_lvl;
  logic                    debug_mode;
  logic                    trace_credit;
  logic                    trace_valid;
  trace_pkg::port_idx_t    trace_port;
  trace_pkg::pc_t          trace_pc;
  trace_pkg::insn_t        trace_insn;
  trace_pkg::cause_t       trace_cause;
  trace_pkg::trace_kind_e  trace_kind;
  trace_pkg::trace_mode_e  trace_mode;
  trace_pkg::cycle_t       trace_cycle;
  logic [`TRACE_PORTS-1:0] overflow;

  // expected records per port as the table loop writes them
  exp_rec_t                exp_buf [`TRACE_PORTS][BufDepth];
  int                      exp_wr  [`TRACE_PORTS];
  int                      exp_rd  [`TRACE_PORTS];
  logic [`TRACE_PORTS-1:0] exp_ovf;
  logic [`TRACE_PORTS-1:0] ovf_d1;
  logic [`TRACE_PORTS-1:0] ovf_d2;

  logic   hold_credits;
  int     outstanding = 0;
  int     owed = 0;
  int     gap = 0;
  integer seed = 75029;
  int     error_count = 0;

  trace_top dut0 (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_insn_i     ( commit_insn     ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_cause_i    ( commit_cause    ),
    .priv_lvl_i        ( priv_lvl        ),
    .debug_mode_i      ( debug_mode      ),
    .trace_credit_i    ( trace_credit    ),
    .trace_valid_o     ( trace_valid     ),
    .trace_port_o      ( trace_port      ),
    .trace_pc_o        ( trace_pc        ),
    .trace_insn_o      ( trace_insn      ),
    .trace_cause_o     ( trace_cause     ),
    .trace_kind_o      ( trace_kind      ),
    .trace_mode_o      ( trace_mode      ),
    .trace_cycle_o     ( trace_cycle     ),
    .overflow_o        ( overflow        )
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count = error_count + 1;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    error_count = error_count + 1;
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // interrupt when the top cause bit is set
  function automatic trace_pkg::trace_kind_e kind_for(input logic ex, input trace_pkg::cause_t c);
    if (!ex) begin
      return trace_pkg::KIND_RETIRE;
    end
    if (c[`TRACE_CAUSE_W-1]) begin
      return trace_pkg::KIND_INTERRUPT;
    end
    return trace_pkg::KIND_EXCEPTION;
  endfunction

  function automatic trace_pkg::trace_mode_e mode_for(input logic dbg, input logic [1:0] priv);
    if (dbg) begin
      return trace_pkg::MODE_D;
    end
    case (priv)
      2'd0:    return trace_pkg::MODE_U;
      2'd1:    return trace_pkg::MODE_S;
      default: return trace_pkg::MODE_M;
    endcase
  endfunction

  function automatic int queued(input int p);
    return exp_wr[p] - exp_rd[p];
  endfunction

  function automatic int pending_total();
    int sum;
    sum = 0;
    for (int p = 0; p < `TRACE_PORTS; p++) begin
      sum = sum + queued(p);
    end
    return sum;
  endfunction

  // ------------------------------------------------------------
  // clock, credit model, scoreboard, watchdog
  // ------------------------------------------------------------
  initial begin
    forever #2 clk = ~clk;
  end

  // each record earns one credit back after a short random gap
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_credit <= 1'b0;
      owed = 0;
      gap = 0;
    end else begin
      trace_credit <= 1'b0;
      if (trace_valid) begin
        owed = owed + 1;
      end
      if (!hold_credits && owed > 0) begin
        if (gap == 0) begin
          trace_credit <= 1'b1;
          owed = owed - 1;
          gap = $random(seed) & 1;
        end else begin
          gap = gap - 1;
        end
      end
    end
  end

  // outputs must sit at their reset values while reset is held
  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("trace_valid_o", trace_valid, 1'b0);
      check_value("overflow_o", overflow, '0);
    end
  end

  always @(posedge clk) begin : scoreboard
    exp_rec_t want;
    int p;
    if (!rst_n) begin
      outstanding = 0;
      ovf_d1 <= '0;
      ovf_d2 <= '0;
    end else begin
      if (trace_credit) begin
        outstanding = outstanding - 1;
      end
      if (trace_valid) begin
        outstanding = outstanding + 1;
        if (outstanding > `TRACE_CREDITS) begin
          report_failure("more trace records were sent than the consumer granted credits for");
        end
        p = int'(trace_port);
        if (queued(p) == 0) begin
          report_failure("a trace record arrived that no commit accounts for");
        end
        want = exp_buf[p][exp_rd[p] % BufDepth];
        exp_rd[p] = exp_rd[p] + 1;
        check_value("trace_pc_o", trace_pc, want.pc);
        check_value("trace_insn_o", trace_insn, want.insn);
        check_value("trace_cause_o", trace_cause, want.cause);
        check_value("trace_kind_o", trace_kind, want.kind);
        check_value("trace_mode_o", trace_mode, want.mode);
        check_value("trace_cycle_o", trace_cycle, want.cycle);
      end
      // flag shows up three edges after the dropped commit is driven
      check_value("overflow_o", overflow, ovf_d2);
      ovf_d1 <= exp_ovf;
      ovf_d2 <= ovf_d1;
    end
  end

  initial begin : watchdog
    #((NumRows + 50) * 4 * 4);
    $display("Timeout: the trace stream did not drain within the expected time");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------
  // table loop
  // ------------------------------------------------------------
  initial begin : main
    vec_row_t row;
    exp_rec_t rec;
    int       cyc;
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_ex_valid = '0;
    priv_lvl        = trace_pkg::PRIV_M;
    debug_mode      = 1'b0;
    trace_credit    = 1'b0;
    hold_credits    = 1'b0;
    exp_ovf         = '0;
    for (int p = 0; p < `TRACE_PORTS; p++) begin
      commit_pc[p]    = '0;
      commit_insn[p]  = '0;
      commit_cause[p] = '0;
      exp_wr[p]       = 0;
      exp_rd[p]       = 0;
    end
    load_table();
    if (row_fill != NumRows) begin
      report_failure("the stimulus table does not hold the declared number of rows");
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    cyc = 0;

    for (int r = 0; r < NumRows; r++) begin
      @(posedge clk);
      cyc = cyc + 1;
      row = vec_table[r];
      commit_ack      <= row.ack;
      commit_ex_valid <= row.ex;
      commit_pc[0]    <= row.pc0;
      commit_pc[1]    <= row.pc1;
      commit_insn[0]  <= row.insn0;
      commit_insn[1]  <= row.insn1;
      commit_cause[0] <= row.cause0;
      commit_cause[1] <= row.cause1;
      priv_lvl        <= trace_pkg::priv_lvl_e'(row.priv);
      debug_mode      <= row.dbg;
      hold_credits    <= row.hold;
      for (int p = 0; p < `TRACE_PORTS; p++) begin
        if (row.ack[p]) begin
          rec.pc    = (p == 0) ? row.pc0 : row.pc1;
          rec.insn  = (p == 0) ? row.insn0 : row.insn1;
          rec.cause = (p == 0) ? row.cause0 : row.cause1;
          rec.kind  = kind_for(row.ex[p], rec.cause);
          rec.mode  = mode_for(row.dbg, row.priv);
          // stamp counts edges from the first one after reset release
          rec.cycle = trace_pkg::cycle_t'(cyc);
          // nothing drains without credits, so a full queue loses the record
          if (row.hold && outstanding == `TRACE_CREDITS &&
              queued(p) >= `TRACE_QUEUE_DEPTH) begin
            exp_ovf[p] <= 1'b1;
          end else begin
            exp_buf[p][exp_wr[p] % BufDepth] = rec;
            exp_wr[p] = exp_wr[p] + 1;
          end
        end
      end
    end

    @(posedge clk);
    commit_ack   <= '0;
    hold_credits <= 1'b0;
    while (pending_total() != 0) begin
      @(posedge clk);
    end
    // late or dropped records would still show up in this quiet period
    repeat (8) @(posedge clk);

    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/commit_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module commit_classifier (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // commit ports
  input  logic [`TRACE_PORTS-1:0]  commit_ack_i,
  input  trace_pkg::pc_t           commit_pc_i       [`TRACE_PORTS],
  input  trace_pkg::insn_t         commit_insn_i     [`TRACE_PORTS],
  input  logic [`TRACE_PORTS-1:0]  commit_ex_valid_i,
  input  trace_pkg::cause_t        commit_cause_i    [`TRACE_PORTS],
  input  trace_pkg::priv_lvl_e     priv_lvl_i,
  input  logic                     debug_mode_i,
  // records towards the queues
  output logic [`TRACE_PORTS-1:0]  push_o,
  output trace_pkg::pc_t           rec_pc_o          [`TRACE_PORTS],
  output trace_pkg::insn_t         rec_insn_o        [`TRACE_PORTS],
  output trace_pkg::cause_t        rec_cause_o       [`TRACE_PORTS],
  output trace_pkg::trace_kind_e   rec_kind_o        [`TRACE_PORTS],
  output trace_pkg::trace_mode_e   rec_mode_o        [`TRACE_PORTS],
  output trace_pkg::cycle_t        rec_cycle_o       [`TRACE_PORTS]
);

  trace_pkg::cycle_t      cycle_q;
  trace_pkg::trace_mode_e mode_d;
  trace_pkg::trace_kind_e kind_d [`TRACE_PORTS];

  // ------------------------------------------------------------
  // classification
  // ------------------------------------------------------------

  // debug wins over the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode_d = trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        trace_pkg::PRIV_U: mode_d = trace_pkg::MODE_U;
        trace_pkg::PRIV_S: mode_d = trace_pkg::MODE_S;
        default:           mode_d = trace_pkg::MODE_M;
      endcase
    end
  end

  // top cause bit splits interrupts from exceptions
  always_comb begin
    for (int p = 0; p < `TRACE_PORTS; p++) begin
      if (!commit_ex_valid_i[p]) begin
        kind_d[p] = trace_pkg::KIND_RETIRE;
      end else if (commit_cause_i[p][`TRACE_CAUSE_W-1]) begin
        kind_d[p] = trace_pkg::KIND_INTERRUPT;
      end else begin
        kind_d[p] = trace_pkg::KIND_EXCEPTION;
      end
    end
  end

  // ------------------------------------------------------------
  // cycle stamp and record registers
  // ------------------------------------------------------------

  // stamp is the count before this edge, so the first edge gives 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
      push_o  <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      push_o  <= commit_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `TRACE_PORTS; p++) begin
      if (commit_ack_i[p]) begin
        rec_pc_o[p]    <= commit_pc_i[p];
        rec_insn_o[p]  <= commit_insn_i[p];
        rec_cause_o[p] <= commit_cause_i[p];
        rec_kind_o[p]  <= kind_d[p];
        rec_mode_o[p]  <= mode_d;
        rec_cycle_o[p] <= cycle_q;
      end
    end
  end

  // reserved privilege encoding must never show up
  priv_lvl_legal_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    priv_lvl_i != 2'b10
  ) else $error("priv_lvl_i took the reserved value 2");

endmodule

`default_nettype wire

/* verilog/trace_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module trace_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // queue heads
  input  logic [`TRACE_PORTS-1:0] empty_i,
  input  trace_pkg::pc_t         head_pc_i    [`TRACE_PORTS],
  input  trace_pkg::insn_t       head_insn_i  [`TRACE_PORTS],
  input  trace_pkg::cause_t      head_cause_i [`TRACE_PORTS],
  input  trace_pkg::trace_kind_e head_kind_i  [`TRACE_PORTS],
  input  trace_pkg::trace_mode_e head_mode_i  [`TRACE_PORTS],
  input  trace_pkg::cycle_t      head_cycle_i [`TRACE_PORTS],
  // one credit back per pulse
  input  logic                   trace_credit_i,
  output logic [`TRACE_PORTS-1:0] pop_o,
  // merged trace stream
  output logic                   trace_valid_o,
  output trace_pkg::port_idx_t   trace_port_o,
  output trace_pkg::pc_t         trace_pc_o,
  output trace_pkg::insn_t       trace_insn_o,
  output trace_pkg::cause_t      trace_cause_o,
  output trace_pkg::trace_kind_e trace_kind_o,
  output trace_pkg::trace_mode_e trace_mode_o,
  output trace_pkg::cycle_t      trace_cycle_o
);

  localparam int unsigned CreditW = $clog2(`TRACE_CREDITS + 1);

  logic [CreditW-1:0]   credit_q;
  logic [CreditW-1:0]   credit_d;
  trace_pkg::port_idx_t rr_q;
  trace_pkg::port_idx_t gnt_idx;
  logic                 gnt_found;
  logic                 grant;

  // ------------------------------------------------------------
  // round-robin search
  // ------------------------------------------------------------

  // start one past the last granted port
  always_comb begin : rr_search
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned off = 1; off <= `TRACE_PORTS; off++) begin
      cand = (rr_q + off) % `TRACE_PORTS;
      if (!gnt_found && !empty_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = trace_pkg::port_idx_t'(cand);
      end
    end
  end

  // no credit means no pop
  assign grant = gnt_found & (credit_q != '0);

  always_comb begin
    pop_o = '0;
    if (grant) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // credit counter
  // ------------------------------------------------------------
  always_comb begin
    credit_d = credit_q;
    if (grant) begin
      credit_d = credit_d - 1'b1;
    end
    if (trace_credit_i) begin
      credit_d = credit_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q      <= CreditW'(`TRACE_CREDITS);
      rr_q          <= trace_pkg::port_idx_t'(`TRACE_PORTS - 1);
      trace_valid_o <= 1'b0;
    end else begin
      credit_q      <= credit_d;
      trace_valid_o <= grant;
      if (grant) begin
        rr_q <= gnt_idx;
      end
    end
  end

  // ------------------------------------------------------------
  // output record
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (grant) begin
      trace_port_o  <= gnt_idx;
      trace_pc_o    <= head_pc_i[gnt_idx];
      trace_insn_o  <= head_insn_i[gnt_idx];
      trace_cause_o <= head_cause_i[gnt_idx];
      trace_kind_o  <= head_kind_i[gnt_idx];
      trace_mode_o  <= head_mode_i[gnt_idx];
      trace_cycle_o <= head_cycle_i[gnt_idx];
    end
  end

  // consumer must not hand back more than it got
  credit_bound_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CreditW'(`TRACE_CREDITS)
  ) else $error("trace credit count above the reset grant");

endmodule

`default_nettype wire

/* verilog/trace_defs.svh */
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// ------------------------------------------------------------
// commit side
// ------------------------------------------------------------

// commit ports reporting per cycle
`define TRACE_PORTS       2

// pc and instruction word widths
`define TRACE_VLEN        32
`define TRACE_INSN_W      32

// top cause bit set means interrupt
`define TRACE_CAUSE_W     8

// free-running stamp, wraps at its width
`define TRACE_CYCLE_W     16

// ------------------------------------------------------------
// trace side
// ------------------------------------------------------------

// default records held per port
`define TRACE_QUEUE_DEPTH 4

// credits owned by the arbiter after reset
`define TRACE_CREDITS     2

`endif

/* verilog/trace_pkg.sv */
`default_nettype none

`include "trace_defs.svh"

package trace_pkg;

  // port index needs at least one bit
  localparam int unsigned PortIdxW = (`TRACE_PORTS > 1) ? $clog2(`TRACE_PORTS) : 1;

  // ------------------------------------------------------------
  // field types
  // ------------------------------------------------------------
  typedef logic [`TRACE_VLEN-1:0]    pc_t;
  typedef logic [`TRACE_INSN_W-1:0]  insn_t;
  typedef logic [`TRACE_CAUSE_W-1:0] cause_t;
  typedef logic [`TRACE_CYCLE_W-1:0] cycle_t;
  typedef logic [PortIdxW-1:0]       port_idx_t;

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    KIND_RETIRE    = 2'd0,
    KIND_EXCEPTION = 2'd1,
    KIND_INTERRUPT = 2'd2
  } trace_kind_e;

  // riscv privilege encoding, 2 is reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // mode letter of the trace record
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } trace_mode_e;

endpackage

`default_nettype wire

/* verilog/trace_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module trace_queue #(
  parameter int unsigned TRACE_QUEUE_DEPTH = `TRACE_QUEUE_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // write side from the classifier
  input  logic                   push_i,
  input  trace_pkg::pc_t         rec_pc_i,
  input  trace_pkg::insn_t       rec_insn_i,
  input  trace_pkg::cause_t      rec_cause_i,
  input  trace_pkg::trace_kind_e rec_kind_i,
  input  trace_pkg::trace_mode_e rec_mode_i,
  input  trace_pkg::cycle_t      rec_cycle_i,
  // read side towards the arbiter
  input  logic                   pop_i,
  output logic                   empty_o,
  output trace_pkg::pc_t         head_pc_o,
  output trace_pkg::insn_t       head_insn_o,
  output trace_pkg::cause_t      head_cause_o,
  output trace_pkg::trace_kind_e head_kind_o,
  output trace_pkg::trace_mode_e head_mode_o,
  output trace_pkg::cycle_t      head_cycle_o,
  output logic                   overflow_o
);

  localparam int unsigned PtrW = (TRACE_QUEUE_DEPTH > 1) ? $clog2(TRACE_QUEUE_DEPTH) : 1;
  localparam int unsigned CntW = $clog2(TRACE_QUEUE_DEPTH + 1);

  trace_pkg::pc_t         pc_mem    [TRACE_QUEUE_DEPTH];
  trace_pkg::insn_t       insn_mem  [TRACE_QUEUE_DEPTH];
  trace_pkg::cause_t      cause_mem [TRACE_QUEUE_DEPTH];
  trace_pkg::trace_kind_e kind_mem  [TRACE_QUEUE_DEPTH];
  trace_pkg::trace_mode_e mode_mem  [TRACE_QUEUE_DEPTH];
  trace_pkg::cycle_t      cycle_mem [TRACE_QUEUE_DEPTH];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            do_push;
  logic            do_pop;
  logic            overflow_q;

  // wrap also for depths that are not a power of two
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(TRACE_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count_q == CntW'(TRACE_QUEUE_DEPTH));
  assign empty_o = (count_q == '0);
  // commits cannot stall, a full queue loses the new record
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // sticky until reset
      if (push_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      pc_mem[wr_ptr_q]    <= rec_pc_i;
      insn_mem[wr_ptr_q]  <= rec_insn_i;
      cause_mem[wr_ptr_q] <= rec_cause_i;
      kind_mem[wr_ptr_q]  <= rec_kind_i;
      mode_mem[wr_ptr_q]  <= rec_mode_i;
      cycle_mem[wr_ptr_q] <= rec_cycle_i;
    end
  end

  assign head_pc_o    = pc_mem[rd_ptr_q];
  assign head_insn_o  = insn_mem[rd_ptr_q];
  assign head_cause_o = cause_mem[rd_ptr_q];
  assign head_kind_o  = kind_mem[rd_ptr_q];
  assign head_mode_o  = mode_mem[rd_ptr_q];
  assign head_cycle_o = cycle_mem[rd_ptr_q];
  assign overflow_o   = overflow_q;

  // arbiter must only pop a queue that holds a record
  pop_not_empty_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o
  ) else $error("pop of an empty trace queue");

endmodule

`default_nettype wire

/* verilog/trace_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module trace_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // commit ports
  input  logic [`TRACE_PORTS-1:0] commit_ack_i,
  input  trace_pkg::pc_t          commit_pc_i       [`TRACE_PORTS],
  input  trace_pkg::insn_t        commit_insn_i     [`TRACE_PORTS],
  input  logic [`TRACE_PORTS-1:0] commit_ex_valid_i,
  input  trace_pkg::cause_t       commit_cause_i    [`TRACE_PORTS],
  input  trace_pkg::priv_lvl_e    priv_lvl_i,
  input  logic                    debug_mode_i,
  // trace stream
  input  logic                    trace_credit_i,
  output logic                    trace_valid_o,
  output trace_pkg::port_idx_t    trace_port_o,
  output trace_pkg::pc_t          trace_pc_o,
  output trace_pkg::insn_t        trace_insn_o,
  output trace_pkg::cause_t       trace_cause_o,
  output trace_pkg::trace_kind_e  trace_kind_o,
  output trace_pkg::trace_mode_e  trace_mode_o,
  output trace_pkg::cycle_t       trace_cycle_o,
  output logic [`TRACE_PORTS-1:0] overflow_o
);

  // ------------------------------------------------------------
  // classifier to queues
  // ------------------------------------------------------------
  logic [`TRACE_PORTS-1:0] push;
  trace_pkg::pc_t          rec_pc    [`TRACE_PORTS];
  trace_pkg::insn_t        rec_insn  [`TRACE_PORTS];
  trace_pkg::cause_t       rec_cause [`TRACE_PORTS];
  trace_pkg::trace_kind_e  rec_kind  [`TRACE_PORTS];
  trace_pkg::trace_mode_e  rec_mode  [`TRACE_PORTS];
  trace_pkg::cycle_t       rec_cycle [`TRACE_PORTS];

  // ------------------------------------------------------------
  // queues to arbiter
  // ------------------------------------------------------------
  logic [`TRACE_PORTS-1:0] empty;
  logic [`TRACE_PORTS-1:0] pop;
  trace_pkg::pc_t          head_pc    [`TRACE_PORTS];
  trace_pkg::insn_t        head_insn  [`TRACE_PORTS];
  trace_pkg::cause_t       head_cause [`TRACE_PORTS];
  trace_pkg::trace_kind_e  head_kind  [`TRACE_PORTS];
  trace_pkg::trace_mode_e  head_mode  [`TRACE_PORTS];
  trace_pkg::cycle_t       head_cycle [`TRACE_PORTS];

  commit_classifier i_commit_classifier (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_insn_i     ( commit_insn_i     ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_cause_i    ( commit_cause_i    ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .push_o            ( push              ),
    .rec_pc_o          ( rec_pc            ),
    .rec_insn_o        ( rec_insn          ),
    .rec_cause_o       ( rec_cause         ),
    .rec_kind_o        ( rec_kind          ),
    .rec_mode_o        ( rec_mode          ),
    .rec_cycle_o       ( rec_cycle         )
  );

  // one queue per commit port
  for (genvar p = 0; p < `TRACE_PORTS; p++) begin : gen_queue
    trace_queue #(
      .TRACE_QUEUE_DEPTH ( `TRACE_QUEUE_DEPTH )
    ) i_trace_queue (
      .clk_i        ( clk_i         ),
      .rst_ni       ( rst_ni        ),
      .push_i       ( push[p]       ),
      .rec_pc_i     ( rec_pc[p]     ),
      .rec_insn_i   ( rec_insn[p]   ),
      .rec_cause_i  ( rec_cause[p]  ),
      .rec_kind_i   ( rec_kind[p]   ),
      .rec_mode_i   ( rec_mode[p]   ),
      .rec_cycle_i  ( rec_cycle[p]  ),
      .pop_i        ( pop[p]        ),
      .empty_o      ( empty[p]      ),
      .head_pc_o    ( head_pc[p]    ),
      .head_insn_o  ( head_insn[p]  ),
      .head_cause_o ( head_cause[p] ),
      .head_kind_o  ( head_kind[p]  ),
      .head_mode_o  ( head_mode[p]  ),
      .head_cycle_o ( head_cycle[p] ),
      .overflow_o   ( overflow_o[p] )
    );
  end

  trace_arbiter i_trace_arbiter (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .empty_i        ( empty          ),
    .head_pc_i      ( head_pc        ),
    .head_insn_i    ( head_insn      ),
    .head_cause_i   ( head_cause     ),
    .head_kind_i    ( head_kind      ),
    .head_mode_i    ( head_mode      ),
    .head_cycle_i   ( head_cycle     ),
    .trace_credit_i ( trace_credit_i ),
    .pop_o          ( pop            ),
    .trace_valid_o  ( trace_valid_o  ),
    .trace_port_o   ( trace_port_o   ),
    .trace_pc_o     ( trace_pc_o     ),
    .trace_insn_o   ( trace_insn_o   ),
    .trace_cause_o  ( trace_cause_o  ),
    .trace_kind_o   ( trace_kind_o   ),
    .trace_mode_o   ( trace_mode_o   ),
    .trace_cycle_o  ( trace_cycle_o  )
  );

endmodule

`default_nettype wire
